// File: rtl/sd_pkg.sv
// Signal-chain constants and sample types shared by the demodulator blocks
package sd_pkg;

    // Channel count and modulator clock division
    localparam int n_channels = 4;
    localparam int clk_div = 4;

    // CIC filter shape, gain is decimation_ratio ** cic_order
    localparam int decimation_ratio = 32;
    localparam int cic_order = 3;
    localparam int cic_gain = 32768;
    localparam int cic_width = 18;

    // Output stream format
    localparam int data_width = 32;
    localparam int dest_width = 4;
    localparam logic [dest_width-1:0] dest_base = 4'd3;

    typedef logic [1:0] chan_idx_t;
    typedef logic signed [cic_width-1:0] sample_t;

endpackage

// File: rtl/sd_reg_pkg.sv
// Register map and AXI4-Lite response codes for the configuration slave
package sd_reg_pkg;

    localparam int axi_addr_width = 8;
    localparam int axi_data_width = 32;

    // Byte offsets of the register groups, four words each except control
    localparam logic [axi_addr_width-1:0] reg_low_base = 8'h00;
    localparam logic [axi_addr_width-1:0] reg_high_base = 8'h10;
    localparam logic [axi_addr_width-1:0] reg_offset_base = 8'h20;
    localparam logic [axi_addr_width-1:0] reg_ctrl = 8'h30;

    // Twelve threshold and offset words plus the control word
    localparam int reg_count = 13;

    localparam logic [1:0] axi_resp_okay = 2'b00;
    localparam logic [1:0] axi_resp_slverr = 2'b10;

endpackage

// File: rtl/sd_stream_if.sv
// Valid/ready stream of filtered samples between the arbiter and the fault comparator
`timescale 1ns/1ps

interface sd_stream_if;

    logic              valid;
    logic              ready;
    sd_pkg::sample_t   data;
    sd_pkg::chan_idx_t chan;

    // Data and channel must hold while valid is high and ready is low
    modport source (
        output valid,
        output data,
        output chan,
        input  ready
    );

    modport sink (
        input  valid,
        input  data,
        input  chan,
        output ready
    );

endinterface

// File: rtl/sd_clock_gen.sv
// Modulator clock divider that also issues a one-cycle strobe at each rising edge
`timescale 1ns/1ps

module sd_clock_gen (
    input  logic clk,
    input  logic arst_n,
    input  logic enable,
    output logic mod_clk,
    output logic bit_strobe
);

    logic [$clog2(sd_pkg::clk_div)-1:0] div_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt    <= '0;
            mod_clk    <= 1'b0;
            bit_strobe <= 1'b0;
        end else if (!enable) begin
            div_cnt    <= '0;
            mod_clk    <= 1'b0;
            bit_strobe <= 1'b0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            // High for the first half of the period
            if (div_cnt == 0) begin
                mod_clk <= 1'b1;
            end else if (div_cnt == sd_pkg::clk_div / 2) begin
                mod_clk <= 1'b0;
            end
            bit_strobe <= (div_cnt == 0);
        end
    end

endmodule

// File: rtl/sd_cic_decimator.sv
// Third-order CIC decimator turning one modulator bitstream into signed samples
`timescale 1ns/1ps

module sd_cic_decimator (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            bit_strobe,
    input  logic            bit_in,
    output sd_pkg::sample_t result,
    output logic            result_valid
);

    localparam int order = sd_pkg::cic_order;

    sd_pkg::sample_t x;
    sd_pkg::sample_t integ [order];
    sd_pkg::sample_t comb_dly [order];
    sd_pkg::sample_t comb_in [order+1];
    logic [$clog2(sd_pkg::decimation_ratio)-1:0] dec_cnt;
    logic dec_tick;

    // A one bit counts as +1 and a zero bit as -1
    assign x = bit_in ? sd_pkg::sample_t'(1) : sd_pkg::sample_t'(-1);
    assign dec_tick = bit_strobe && (dec_cnt == sd_pkg::decimation_ratio - 1);

    // Comb chain evaluated only on the decimated tick
    always_comb begin
        comb_in[0] = integ[order-1];
        for (int k = 0; k < order; k++) begin
            comb_in[k+1] = comb_in[k] - comb_dly[k];
        end
    end

    // Integrators wrap on overflow and the combs undo it at the output
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_cnt      <= '0;
            result_valid <= 1'b0;
            for (int k = 0; k < order; k++) begin
                integ[k]    <= '0;
                comb_dly[k] <= '0;
            end
        end else begin
            result_valid <= dec_tick;
            if (bit_strobe) begin
                dec_cnt  <= dec_tick ? '0 : dec_cnt + 1'b1;
                integ[0] <= integ[0] + x;
                for (int k = 1; k < order; k++) begin
                    integ[k] <= integ[k] + integ[k-1];
                end
            end
            if (dec_tick) begin
                for (int k = 0; k < order; k++) begin
                    comb_dly[k] <= comb_in[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dec_tick) begin
            result <= comb_in[order];
        end
    end

    // A full-scale input bounds every result to plus or minus the filter gain
    a_result_in_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        result_valid |-> (int'(result) <= sd_pkg::cic_gain) &&
                         (int'(result) >= -sd_pkg::cic_gain)
    );

endmodule

// File: rtl/sd_output_arbiter.sv
// Round-robin collector that serializes per-channel filter results onto the stream
`timescale 1ns/1ps

module sd_output_arbiter (
    input  logic                          clk,
    input  logic                          arst_n,
    input  sd_pkg::sample_t               results [sd_pkg::n_channels],
    input  logic [sd_pkg::n_channels-1:0] result_valid,
    sd_stream_if.source                   stream
);

    logic [sd_pkg::n_channels-1:0] pending;
    sd_pkg::sample_t   values [sd_pkg::n_channels];
    sd_pkg::chan_idx_t rr_ptr;
    sd_pkg::chan_idx_t cand;
    sd_pkg::chan_idx_t grant_idx;
    logic grant_found;
    logic take;

    // Search starts at the channel after the last one granted
    always_comb begin
        grant_found = 1'b0;
        grant_idx   = rr_ptr;
        cand        = rr_ptr;
        for (int k = 0; k < sd_pkg::n_channels; k++) begin
            cand = rr_ptr + sd_pkg::chan_idx_t'(k);
            if (!grant_found && pending[cand]) begin
                grant_found = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    assign take = grant_found && (!stream.valid || stream.ready);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pending      <= '0;
            rr_ptr       <= '0;
            stream.valid <= 1'b0;
        end else begin
            if (!stream.valid || stream.ready) begin
                stream.valid <= grant_found;
            end
            if (take) begin
                rr_ptr <= grant_idx + 1'b1;
            end
            // A fresh result re-arms its channel even when the old one is taken now
            for (int i = 0; i < sd_pkg::n_channels; i++) begin
                if (result_valid[i]) begin
                    pending[i] <= 1'b1;
                end else if (take && grant_idx == sd_pkg::chan_idx_t'(i)) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < sd_pkg::n_channels; i++) begin
            if (result_valid[i]) begin
                values[i] <= results[i];
            end
        end
        if (take) begin
            stream.data <= values[grant_idx];
            stream.chan <= grant_idx;
        end
    end

    // The round-robin order relies on all decimators finishing in the same cycle
    a_results_lockstep: assert property (
        @(posedge clk) disable iff (!arst_n)
        (|result_valid) |-> (&result_valid)
    );

endmodule

// File: rtl/sd_fault_compare.sv
// Output stage that removes the channel offset, checks thresholds and tags the destination
`timescale 1ns/1ps

module sd_fault_compare (
    input  logic                          clk,
    input  logic                          arst_n,
    sd_stream_if.sink                     stream,
    input  sd_pkg::sample_t               low_thr [sd_pkg::n_channels],
    input  sd_pkg::sample_t               high_thr [sd_pkg::n_channels],
    input  sd_pkg::sample_t               offset [sd_pkg::n_channels],
    output logic                          out_valid,
    input  logic                          out_ready,
    output logic [sd_pkg::data_width-1:0] out_data,
    output logic [sd_pkg::dest_width-1:0] out_dest,
    output logic [1:0]                    out_fault
);

    logic signed [sd_pkg::data_width-1:0] data_ext;
    logic signed [sd_pkg::data_width-1:0] offset_ext;
    logic signed [sd_pkg::data_width-1:0] low_ext;
    logic signed [sd_pkg::data_width-1:0] high_ext;
    logic signed [sd_pkg::data_width-1:0] corrected;

    // Everything is widened first so the subtraction cannot wrap
    assign data_ext   = stream.data;
    assign offset_ext = offset[stream.chan];
    assign low_ext    = low_thr[stream.chan];
    assign high_ext   = high_thr[stream.chan];
    assign corrected  = data_ext - offset_ext;

    assign stream.ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (stream.ready) begin
            out_valid <= stream.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (stream.valid && stream.ready) begin
            out_data     <= corrected;
            out_dest     <= sd_pkg::dest_base + {2'b00, stream.chan};
            out_fault[0] <= corrected < low_ext;
            out_fault[1] <= corrected > high_ext;
        end
    end

endmodule

// File: rtl/sd_regs.sv
// AXI4-Lite slave holding the per-channel thresholds, offsets and the filter enable
`timescale 1ns/1ps

module sd_regs (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [sd_reg_pkg::axi_addr_width-1:0] awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [sd_reg_pkg::axi_data_width-1:0] wdata,
    input  logic [3:0]                            wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [sd_reg_pkg::axi_addr_width-1:0] araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [sd_reg_pkg::axi_data_width-1:0] rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output sd_pkg::sample_t                       low_thr [sd_pkg::n_channels],
    output sd_pkg::sample_t                       high_thr [sd_pkg::n_channels],
    output sd_pkg::sample_t                       offset [sd_pkg::n_channels],
    output logic                                  enable
);

    logic [sd_reg_pkg::axi_data_width-1:0] regs [sd_reg_pkg::reg_count];
    logic [4:0] wr_dec;
    logic [4:0] rd_dec;
    logic wr_fire;
    logic rd_fire;

    // Returns {hit, index} with the group number in the upper index bits
    function automatic logic [4:0] decode(input logic [sd_reg_pkg::axi_addr_width-1:0] addr);
        logic [sd_reg_pkg::axi_addr_width-1:0] group;
        group = {addr[7:4], 4'h0};
        if (addr[1:0] != 2'b00) begin
            return 5'd0;
        end
        case (group)
            sd_reg_pkg::reg_low_base:    return {1'b1, 2'd0, addr[3:2]};
            sd_reg_pkg::reg_high_base:   return {1'b1, 2'd1, addr[3:2]};
            sd_reg_pkg::reg_offset_base: return {1'b1, 2'd2, addr[3:2]};
            sd_reg_pkg::reg_ctrl:        return {addr[3:2] == 2'd0, 2'd3, 2'd0};
            default:                     return 5'd0;
        endcase
    endfunction

    assign wr_dec  = decode(awaddr);
    assign rd_dec  = decode(araddr);
    assign wr_fire = awready && awvalid && wvalid;
    assign rd_fire = arready && arvalid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= sd_reg_pkg::axi_resp_okay;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= sd_reg_pkg::axi_resp_okay;
            rdata   <= '0;
            for (int i = 0; i < sd_reg_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            // Address and data are taken together in a single accept cycle
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= wr_dec[4] ? sd_reg_pkg::axi_resp_okay : sd_reg_pkg::axi_resp_slverr;
                for (int b = 0; b < 4; b++) begin
                    if (wr_dec[4] && wstrb[b]) begin
                        regs[wr_dec[3:0]][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            arready <= arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
                rresp  <= rd_dec[4] ? sd_reg_pkg::axi_resp_okay : sd_reg_pkg::axi_resp_slverr;
                rdata  <= rd_dec[4] ? regs[rd_dec[3:0]] : '0;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < sd_pkg::n_channels; i++) begin
            low_thr[i]  = regs[i][sd_pkg::cic_width-1:0];
            high_thr[i] = regs[sd_pkg::n_channels + i][sd_pkg::cic_width-1:0];
            offset[i]   = regs[2 * sd_pkg::n_channels + i][sd_pkg::cic_width-1:0];
        end
    end

    assign enable = regs[sd_reg_pkg::reg_count-1][0];

    // Address and data stay valid until the slave accepts them
    a_write_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        awvalid && wvalid && !awready |=> awvalid && wvalid
    );

endmodule

// File: rtl/sigma_delta_processor.sv
// Four-channel sigma-delta demodulator top with AXI4-Lite configuration and sample output
`timescale 1ns/1ps

module sigma_delta_processor (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic [sd_pkg::n_channels-1:0]         bitstream_in,
    output logic                                  mod_clk,
    input  logic [sd_reg_pkg::axi_addr_width-1:0] awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [sd_reg_pkg::axi_data_width-1:0] wdata,
    input  logic [3:0]                            wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [sd_reg_pkg::axi_addr_width-1:0] araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [sd_reg_pkg::axi_data_width-1:0] rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic                                  out_valid,
    input  logic                                  out_ready,
    output logic [sd_pkg::data_width-1:0]         out_data,
    output logic [sd_pkg::dest_width-1:0]         out_dest,
    output logic [1:0]                            out_fault
);

    sd_pkg::sample_t low_thr [sd_pkg::n_channels];
    sd_pkg::sample_t high_thr [sd_pkg::n_channels];
    sd_pkg::sample_t offset [sd_pkg::n_channels];
    sd_pkg::sample_t results [sd_pkg::n_channels];
    logic [sd_pkg::n_channels-1:0] result_valid;
    logic enable;
    logic bit_strobe;

    sd_stream_if stream ();

    sd_regs u_regs (
        .clk, .arst_n,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .low_thr, .high_thr, .offset, .enable
    );

    sd_clock_gen u_clock_gen (
        .clk, .arst_n, .enable, .mod_clk, .bit_strobe
    );

    // All decimators share the strobe and stay in lockstep
    for (genvar i = 0; i < sd_pkg::n_channels; i++) begin : g_chan
        sd_cic_decimator u_cic (
            .clk,
            .arst_n,
            .bit_strobe,
            .bit_in       (bitstream_in[i]),
            .result       (results[i]),
            .result_valid (result_valid[i])
        );
    end

    sd_output_arbiter u_arbiter (
        .clk, .arst_n, .results, .result_valid, .stream (stream.source)
    );

    sd_fault_compare u_fault (
        .clk, .arst_n, .stream (stream.sink),
        .low_thr, .high_thr, .offset,
        .out_valid, .out_ready, .out_data, .out_dest, .out_fault
    );

endmodule

// File: verif/sigma_delta_processor_tb.sv
// Table-driven testbench that runs channel patterns through the demodulator and checks the stream
`timescale 1ns/1ps

module sigma_delta_processor_tb;

    localparam int n_ch = sd_pkg::n_channels;
    localparam int n_rows = 3;
    localparam int skip_words = 5;
    localparam int check_words = 4;
    localparam int frame_cycles = sd_pkg::decimation_ratio * sd_pkg::clk_div;
    localparam longint timeout_ns =
        longint'(n_rows) * (skip_words + check_words) * 256 * 40 + 200000;

    // Repeating bit patterns for the modulator inputs
    localparam int pat_ones = 0;
    localparam int pat_zeros = 1;
    localparam int pat_alt = 2;
    localparam int pat_three_one = 3;

    logic clk;
    logic arst_n;
    wire  [n_ch-1:0] bitstream_in;
    logic mod_clk;
    logic [sd_reg_pkg::axi_addr_width-1:0] awaddr;
    logic awvalid;
    logic awready;
    logic [sd_reg_pkg::axi_data_width-1:0] wdata;
    logic [3:0] wstrb;
    logic wvalid;
    logic wready;
    logic [1:0] bresp;
    logic bvalid;
    logic bready;
    logic [sd_reg_pkg::axi_addr_width-1:0] araddr;
    logic arvalid;
    logic arready;
    logic [sd_reg_pkg::axi_data_width-1:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;
    logic out_valid;
    logic out_ready;
    logic [sd_pkg::data_width-1:0] out_data;
    logic [sd_pkg::dest_width-1:0] out_dest;
    logic [1:0] out_fault;

    // Stimulus and expected results with one row per test case
    int pat_tab [n_rows][n_ch];
    int off_tab [n_rows][n_ch];
    int low_tab [n_rows][n_ch];
    int high_tab [n_rows][n_ch];
    int exp_tab [n_rows][n_ch];
    logic [1:0] fault_tab [n_rows][n_ch];
    bit stall_tab [n_rows];

    int cur_row = 0;
    int seen_row = -1;
    int next_chan = 0;
    int got_count [n_ch];
    bit stall_en = 1'b0;

    sigma_delta_processor dut (.*);

    task automatic set_entry(input int row, input int ch, input int pat, input int off,
                             input int low, input int high, input int exp_val,
                             input logic [1:0] exp_fault);
        pat_tab[row][ch]   = pat;
        off_tab[row][ch]   = off;
        low_tab[row][ch]   = low;
        high_tab[row][ch]  = high;
        exp_tab[row][ch]   = exp_val;
        fault_tab[row][ch] = exp_fault;
    endtask

    // Expected value is 32768 times the pattern mean minus the offset
    task automatic load_table();
        set_entry(0, 0, pat_ones,      0,       -40000, 40000,  32768,  2'b00);
        set_entry(0, 1, pat_zeros,     0,       -30000, 30000,  -32768, 2'b01);
        set_entry(0, 2, pat_alt,       -200,    -50,    50,     200,    2'b10);
        set_entry(0, 3, pat_three_one, 1000,    0,      20000,  15384,  2'b00);
        set_entry(1, 0, pat_zeros,     -32768,  -10,    10,     0,      2'b00);
        set_entry(1, 1, pat_ones,      2768,    0,      20000,  30000,  2'b10);
        set_entry(1, 2, pat_three_one, 16384,   1,      5,      0,      2'b01);
        set_entry(1, 3, pat_alt,       0,       -1,     1,      0,      2'b00);
        set_entry(2, 0, pat_alt,       5000,    -6000,  -4000,  -5000,  2'b00);
        set_entry(2, 1, pat_three_one, -100000, 0,      116383, 116384, 2'b10);
        set_entry(2, 2, pat_ones,      32768,   0,      0,      0,      2'b00);
        set_entry(2, 3, pat_zeros,     0,       -32768, 0,      -32768, 2'b00);
        stall_tab[0] = 1'b0;
        stall_tab[1] = 1'b0;
        stall_tab[2] = 1'b1;
    endtask

    function automatic logic pattern_bit(input int pat, input int phase);
        case (pat)
            pat_ones:  return 1'b1;
            pat_zeros: return 1'b0;
            pat_alt:   return (phase % 2) == 0;
            default:   return (phase % 4) != 3;
        endcase
    endfunction

    task automatic report_fail(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // The destination is checked on every word, data and fault only when with_value is set
    task automatic check_word(input logic [sd_pkg::data_width-1:0] got_data,
                              input logic [sd_pkg::dest_width-1:0] got_dest,
                              input logic [1:0] got_fault, input int row, input int ch,
                              input bit with_value);
        logic [sd_pkg::data_width-1:0] exp_data;
        logic [sd_pkg::dest_width-1:0] exp_dest;
        exp_data = exp_tab[row][ch];
        exp_dest = sd_pkg::dest_base + ch[sd_pkg::dest_width-1:0];
        if (got_dest !== exp_dest) begin
            report_fail($sformatf("round-robin order broken: dest %0d, expected %0d",
                got_dest, exp_dest));
        end
        if (with_value && (got_data !== exp_data || got_fault !== fault_tab[row][ch])) begin
            report_fail($sformatf("row %0d ch %0d: data %0d fault %b, expected %0d %b",
                row, ch, $signed(got_data), got_fault,
                $signed(exp_data), fault_tab[row][ch]));
        end
    endtask

    task automatic check_read(input logic [sd_reg_pkg::axi_data_width-1:0] got_data,
                              input logic [1:0] got_resp,
                              input logic [sd_reg_pkg::axi_data_width-1:0] exp_data,
                              input logic [1:0] exp_resp, input string what);
        if (got_data !== exp_data || got_resp !== exp_resp) begin
            report_fail($sformatf("%s: rdata 0x%08h rresp %b, expected 0x%08h %b",
                what, got_data, got_resp, exp_data, exp_resp));
        end
    endtask

    task automatic check_bresp(input logic [1:0] got_resp, input logic [1:0] exp_resp,
                               input string what);
        if (got_resp !== exp_resp) begin
            report_fail($sformatf("%s: bresp %b, expected %b", what, got_resp, exp_resp));
        end
    endtask

    task automatic axi_write(input logic [sd_reg_pkg::axi_addr_width-1:0] addr,
                             input logic [sd_reg_pkg::axi_data_width-1:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        #2;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge clk); while (!awready);
        if (wready !== 1'b1) begin
            report_fail($sformatf("write to 0x%02h: wready did not come with awready", addr));
        end
        #2;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        #2;
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [sd_reg_pkg::axi_addr_width-1:0] addr,
                            output logic [sd_reg_pkg::axi_data_width-1:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        #2;
        araddr  = addr;
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge clk); while (!arready);
        #2;
        arvalid = 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        #2;
        rready = 1'b0;
    endtask

    task automatic write_verify(input logic [sd_reg_pkg::axi_addr_width-1:0] addr,
                                input logic [sd_reg_pkg::axi_data_width-1:0] data);
        logic [sd_reg_pkg::axi_data_width-1:0] rd;
        logic [1:0] resp;
        axi_write(addr, data, resp);
        check_bresp(resp, sd_reg_pkg::axi_resp_okay, $sformatf("write to 0x%02h", addr));
        axi_read(addr, rd, resp);
        check_read(rd, resp, data, sd_reg_pkg::axi_resp_okay,
            $sformatf("readback of 0x%02h", addr));
    endtask

    function automatic bit row_complete();
        for (int i = 0; i < n_ch; i++) begin
            if (got_count[i] < skip_words + check_words) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            if (out_valid !== 1'b0 || mod_clk !== 1'b0) begin
                report_fail($sformatf("filters disabled but out_valid %b mod_clk %b",
                    out_valid, mod_clk));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Each channel shifts its pattern out one bit per modulator clock
    for (genvar c = 0; c < n_ch; c++) begin : g_bit_drv
        logic bit_q;
        int phase;
        int row;
        assign bitstream_in[c] = bit_q;
        initial begin
            bit_q = 1'b0;
            phase = 0;
        end
        always @(posedge mod_clk) begin
            row = cur_row;
            #2;
            bit_q = pattern_bit(pat_tab[row][c], phase);
            phase = phase + 1;
        end
    end

    // Back-pressure comes in bursts and low runs stay well under 200 cycles
    initial begin : ready_driver
        int run;
        bit stall_now;
        void'($urandom(32'h6533));
        out_ready = 1'b1;
        run = 0;
        forever begin
            @(posedge clk);
            stall_now = stall_en;
            #2;
            if (run > 0) begin
                run = run - 1;
            end else if (stall_now) begin
                out_ready = !out_ready;
                run = out_ready ? $urandom_range(20, 4) : $urandom_range(40, 1);
            end else begin
                out_ready = 1'b1;
            end
        end
    end

    always @(posedge clk) begin : stream_monitor
        int ch;
        bit in_window;
        if (cur_row != seen_row) begin
            seen_row = cur_row;
            for (int i = 0; i < n_ch; i++) begin
                got_count[i] = 0;
            end
        end
        if (arst_n && out_valid && out_ready) begin
            ch = next_chan;
            next_chan = (next_chan + 1) % n_ch;
            got_count[ch] = got_count[ch] + 1;
            // Early words of a row are filter fill
            in_window = got_count[ch] > skip_words && got_count[ch] <= skip_words + check_words;
            check_word(out_data, out_dest, out_fault, seen_row, ch, in_window);
        end
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns, the DUT stopped responding",
            timeout_ns);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : main_seq
        logic [sd_reg_pkg::axi_data_width-1:0] rd;
        logic [1:0] resp;
        arst_n  = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        load_table();
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        axi_read(8'h34, rd, resp);
        check_read(rd, resp, '0, sd_reg_pkg::axi_resp_slverr, "read of unmapped 0x34");
        axi_read(8'h06, rd, resp);
        check_read(rd, resp, '0, sd_reg_pkg::axi_resp_slverr, "misaligned read of 0x06");
        axi_write(8'h40, 32'ha5a5_5a5a, resp);
        check_bresp(resp, sd_reg_pkg::axi_resp_slverr, "write to unmapped 0x40");
        axi_read(8'h40, rd, resp);
        check_read(rd, resp, '0, sd_reg_pkg::axi_resp_slverr, "read of unmapped 0x40");

        for (int row = 0; row < n_rows; row++) begin
            for (int ch = 0; ch < n_ch; ch++) begin
                write_verify(sd_reg_pkg::reg_low_base + 8'(4 * ch), low_tab[row][ch]);
                write_verify(sd_reg_pkg::reg_high_base + 8'(4 * ch), high_tab[row][ch]);
                write_verify(sd_reg_pkg::reg_offset_base + 8'(4 * ch), off_tab[row][ch]);
            end
            write_verify(sd_reg_pkg::reg_ctrl, 32'd1);
            stall_en = stall_tab[row];
            cur_row = row;
            do begin
                @(posedge clk);
                #2;
            end while (!row_complete());
            stall_en = 1'b0;
        end

        // Disabled filters must keep the stream and the modulator clock quiet
        write_verify(sd_reg_pkg::reg_ctrl, 32'd0);
        repeat (16) @(posedge clk);
        check_idle(frame_cycles + 16);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: build.f
rtl/sd_pkg.sv
rtl/sd_reg_pkg.sv
rtl/sd_stream_if.sv
rtl/sd_clock_gen.sv
rtl/sd_cic_decimator.sv
rtl/sd_output_arbiter.sv
rtl/sd_fault_compare.sv
rtl/sd_regs.sv
rtl/sigma_delta_processor.sv
verif/sigma_delta_processor_tb.sv

// File: Makefile
VERILATOR  ?= verilator
FILELIST   := build.f
TB_TOP     := sigma_delta_processor_tb
DUT_TOP    := sigma_delta_processor
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
OBJ_DIR    := obj_dir
SIM_BIN    := sim_tb
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(DUT_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	-./$(OBJ_DIR)/$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
